/* design/periph_pkg.sv */
// register map, request opcodes and bus widths
// shared by the router, the gpio block and the uart transmitter

package periph_pkg;

  // width of request write data and response read data
  localparam int DATA_W = 8;

  // led outputs and dip switch inputs
  localparam int LED_W = 8;
  localparam int SW_W  = 4;

  // register addresses seen by the host
  typedef enum logic [1:0] {
    // led output register, read/write/set/clear
    REG_LED       = 2'd0,
    // synchronized switches, read only
    REG_SW        = 2'd1,
    // uart transmit byte, write starts a frame
    REG_UART_DATA = 2'd2,
    // uart status, bit 0 is busy, read only
    REG_UART_STAT = 2'd3
  } reg_addr_e;

  // request opcodes
  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    // or the write data into the register
    OP_SET   = 2'd2,
    // and-not the write data out of the register
    OP_CLEAR = 2'd3
  } bus_op_e;

endpackage

/* design/uart_pkg.sv */
// uart frame constants and transmitter state encoding

package uart_pkg;

  // 8n1 frame, data bits go out lsb first
  localparam int DATA_BITS = 8;

  // line levels of the framing bits
  localparam logic START_BIT = 1'b0;
  // stop bit level is also the idle level
  localparam logic STOP_BIT  = 1'b1;

  // transmitter fsm states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    START = 2'd1,
    DATA  = 2'd2,
    STOP  = 2'd3
  } tx_state_e;

endpackage

/* design/reg_bus_if.sv */
// register request/response channel between the router and one target
// host and target modports

interface reg_bus_if;

  // request channel, transfers when valid and ready are both high
  logic                          req_valid;
  logic                          req_ready;
  periph_pkg::bus_op_e           req_op;
  periph_pkg::reg_addr_e         req_addr;
  logic [periph_pkg::DATA_W-1:0] req_wdata;

  // response channel, one pulse per accepted request, no ready
  logic                          rsp_valid;
  logic [periph_pkg::DATA_W-1:0] rsp_rdata;

  // router side
  modport host (
    output req_valid, req_op, req_addr, req_wdata,
    input  req_ready, rsp_valid, rsp_rdata
  );

  // register block side
  modport target (
    input  req_valid, req_op, req_addr, req_wdata,
    output req_ready, rsp_valid, rsp_rdata
  );

endinterface

/* design/gpio_regs.sv */
// gpio register block
// led register with write, set and clear
// two flop synchronizer on the dip switch inputs

module gpio_regs (
  input  logic                          clk,
  input  logic                          i_rst,
  reg_bus_if.target                     bus,
  input  logic [periph_pkg::SW_W-1:0]   i_sw,
  output logic [periph_pkg::LED_W-1:0]  o_led
);

  logic [periph_pkg::LED_W-1:0]  led_q;
  logic [periph_pkg::LED_W-1:0]  led_next;
  // switch synchronizer stages
  logic [periph_pkg::SW_W-1:0]   sw_meta_q;
  logic [periph_pkg::SW_W-1:0]   sw_sync_q;
  logic                          take;
  logic                          led_hit;
  logic                          rsp_valid_q;
  logic [periph_pkg::DATA_W-1:0] rsp_rdata_q;

  // register writes never stall
  assign bus.req_ready = 1'b1;
  assign take          = bus.req_valid && bus.req_ready;
  // router only sends set/clear to the led register
  assign led_hit       = take && (bus.req_addr == periph_pkg::REG_LED);

  // next led value for the accepted opcode
  always_comb begin
    led_next = led_q;
    if (led_hit) begin
      case (bus.req_op)
        periph_pkg::OP_WRITE: led_next = bus.req_wdata[periph_pkg::LED_W-1:0];
        periph_pkg::OP_SET:   led_next = led_q | bus.req_wdata[periph_pkg::LED_W-1:0];
        periph_pkg::OP_CLEAR: led_next = led_q & ~bus.req_wdata[periph_pkg::LED_W-1:0];
        default:              led_next = led_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      led_q       <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      led_q       <= led_next;
      // answer in the cycle after acceptance
      rsp_valid_q <= take;
    end
  end

  // switches are asynchronous to clk
  always_ff @(posedge clk) begin
    sw_meta_q <= i_sw;
    sw_sync_q <= sw_meta_q;
  end

  // read data, switches zero extended
  // writes return the updated led value
  always_ff @(posedge clk) begin
    rsp_rdata_q <= '0;
    if (bus.req_addr == periph_pkg::REG_SW) begin
      rsp_rdata_q[periph_pkg::SW_W-1:0] <= sw_sync_q;
    end else begin
      rsp_rdata_q[periph_pkg::LED_W-1:0] <= led_next;
    end
  end

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_rdata = rsp_rdata_q;
  assign o_led         = led_q;

endmodule

/* design/uart_tx.sv */
// 8n1 uart transmitter
// fsm with bit period counter and bit index
// busy status readable on the register bus

module uart_tx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic      clk,
  input  logic      i_rst,
  reg_bus_if.target bus,
  output logic      o_uart_tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int IDX_W = $clog2(uart_pkg::DATA_BITS);

  uart_pkg::tx_state_e            state_q;
  // cycles spent in the current bit
  logic [CNT_W-1:0]               cnt_q;
  // data bit being sent
  logic [IDX_W-1:0]               idx_q;
  logic [uart_pkg::DATA_BITS-1:0] shift_q;
  logic                           tx_q;
  logic                           busy;
  logic                           take;
  logic                           load;
  logic                           bit_end;
  logic                           rsp_valid_q;
  logic [periph_pkg::DATA_W-1:0]  rsp_rdata_q;

  assign busy    = (state_q != uart_pkg::IDLE);
  // status reads still pass while a frame is going out
  assign bus.req_ready = !busy || (bus.req_op == periph_pkg::OP_READ);
  assign take    = bus.req_valid && bus.req_ready;
  // only reachable when idle since writes stall while busy
  assign load    = take && (bus.req_op == periph_pkg::OP_WRITE)
                 && (bus.req_addr == periph_pkg::REG_UART_DATA);
  assign bit_end = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q <= uart_pkg::IDLE;
      cnt_q   <= '0;
      idx_q   <= '0;
      tx_q    <= uart_pkg::STOP_BIT;
    end else begin
      case (state_q)
        uart_pkg::IDLE: begin
          // start bit goes out the cycle after acceptance
          if (load) begin
            state_q <= uart_pkg::START;
            cnt_q   <= '0;
            tx_q    <= uart_pkg::START_BIT;
          end
        end
        uart_pkg::START: begin
          if (bit_end) begin
            state_q <= uart_pkg::DATA;
            cnt_q   <= '0;
            idx_q   <= '0;
            tx_q    <= shift_q[0];
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        uart_pkg::DATA: begin
          if (bit_end) begin
            cnt_q <= '0;
            if (idx_q == IDX_W'(uart_pkg::DATA_BITS - 1)) begin
              state_q <= uart_pkg::STOP;
              tx_q    <= uart_pkg::STOP_BIT;
            end else begin
              idx_q <= idx_q + 1'b1;
              tx_q  <= shift_q[0];
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        uart_pkg::STOP: begin
          if (bit_end) begin
            state_q <= uart_pkg::IDLE;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= uart_pkg::IDLE;
      endcase
    end
  end

  // lsb first so the next bit always sits in shift_q[0]
  always_ff @(posedge clk) begin
    if (load) begin
      shift_q <= bus.req_wdata[uart_pkg::DATA_BITS-1:0];
    end else if (bit_end && (state_q == uart_pkg::START || state_q == uart_pkg::DATA)) begin
      shift_q <= shift_q >> 1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= take;
    end
  end

  // status register holds busy in bit 0 and the data register reads as zero
  always_ff @(posedge clk) begin
    rsp_rdata_q <= '0;
    if (bus.req_addr == periph_pkg::REG_UART_STAT) begin
      rsp_rdata_q[0] <= busy;
    end
  end

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_rdata = rsp_rdata_q;
  assign o_uart_tx     = tx_q;

  // line idles high
  a_idle_high: assert property (
    @(posedge clk) disable iff (i_rst)
    (state_q == uart_pkg::IDLE) |-> o_uart_tx
  );

endmodule

/* design/bus_router.sv */
// request router between the host port and the gpio and uart blocks
// address decode, illegal op detection, hold until target ready
// registered response merge with error flag

module bus_router (
  input  logic                          clk,
  input  logic                          i_rst,
  input  logic                          i_req_valid,
  output logic                          o_req_ready,
  input  periph_pkg::bus_op_e           i_req_op,
  input  periph_pkg::reg_addr_e         i_req_addr,
  input  logic [periph_pkg::DATA_W-1:0] i_req_wdata,
  output logic                          o_rsp_valid,
  output logic [periph_pkg::DATA_W-1:0] o_rsp_rdata,
  output logic                          o_rsp_err,
  reg_bus_if.host                       gpio_bus,
  reg_bus_if.host                       uart_bus
);

  // request held for forwarding
  logic                          pend_q;
  // forwarded and waiting for the response merge
  logic                          wait_q;
  periph_pkg::bus_op_e           op_q;
  periph_pkg::reg_addr_e         addr_q;
  logic [periph_pkg::DATA_W-1:0] wdata_q;
  logic                          err_q;
  logic                          uart_sel_q;
  logic                          accept;
  logic                          illegal;
  logic                          uart_sel;
  logic                          fwd_ready;
  logic                          fwd_done;
  logic                          rsp_any;

  // one request in flight
  assign o_req_ready = !pend_q && !wait_q;
  assign accept      = i_req_valid && o_req_ready;

  // set/clear only on leds and no writes to switches or status
  assign illegal = (((i_req_op == periph_pkg::OP_SET) || (i_req_op == periph_pkg::OP_CLEAR))
                    && (i_req_addr != periph_pkg::REG_LED))
                 || ((i_req_op == periph_pkg::OP_WRITE)
                    && ((i_req_addr == periph_pkg::REG_SW)
                    || (i_req_addr == periph_pkg::REG_UART_STAT)));
  assign uart_sel = (i_req_addr == periph_pkg::REG_UART_DATA)
                 || (i_req_addr == periph_pkg::REG_UART_STAT);

  // errors are answered locally without a target handshake
  assign fwd_ready = err_q || (uart_sel_q ? uart_bus.req_ready : gpio_bus.req_ready);
  assign fwd_done  = pend_q && fwd_ready;
  assign rsp_any   = gpio_bus.rsp_valid || uart_bus.rsp_valid;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      pend_q      <= 1'b0;
      wait_q      <= 1'b0;
      o_rsp_valid <= 1'b0;
      o_rsp_err   <= 1'b0;
    end else begin
      if (accept) begin
        pend_q <= 1'b1;
      end else if (fwd_done) begin
        pend_q <= 1'b0;
      end
      if (fwd_done) begin
        wait_q <= 1'b1;
      end else if (wait_q && (err_q || rsp_any)) begin
        wait_q <= 1'b0;
      end
      o_rsp_valid <= wait_q && (err_q || rsp_any);
      o_rsp_err   <= wait_q && err_q;
    end
  end

  // request capture and merged read data
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q       <= i_req_op;
      addr_q     <= i_req_addr;
      wdata_q    <= i_req_wdata;
      err_q      <= illegal;
      uart_sel_q <= uart_sel;
    end
    if (err_q || !rsp_any) begin
      o_rsp_rdata <= '0;
    end else begin
      o_rsp_rdata <= uart_bus.rsp_valid ? uart_bus.rsp_rdata : gpio_bus.rsp_rdata;
    end
  end

  // payload goes to both but valid only to the selected one
  assign gpio_bus.req_valid = pend_q && !err_q && !uart_sel_q;
  assign gpio_bus.req_op    = op_q;
  assign gpio_bus.req_addr  = addr_q;
  assign gpio_bus.req_wdata = wdata_q;
  assign uart_bus.req_valid = pend_q && !err_q && uart_sel_q;
  assign uart_bus.req_op    = op_q;
  assign uart_bus.req_addr  = addr_q;
  assign uart_bus.req_wdata = wdata_q;

  // a request only ever reaches one block
  a_one_rsp: assert property (
    @(posedge clk) disable iff (i_rst)
    !(gpio_bus.rsp_valid && uart_bus.rsp_valid)
  );

  // host port reopens only together with the response of the outstanding request
  a_outstanding: assert property (
    @(posedge clk) disable iff (i_rst)
    $rose(o_req_ready) |-> o_rsp_valid
  );

endmodule

/* design/periph_top.sv */
// peripheral subsystem top level
// host register port, router, gpio block and uart transmitter

module periph_top #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic                          clk,
  input  logic                          i_rst,
  // host request channel
  input  logic                          i_req_valid,
  output logic                          o_req_ready,
  input  periph_pkg::bus_op_e           i_req_op,
  input  periph_pkg::reg_addr_e         i_req_addr,
  input  logic [periph_pkg::DATA_W-1:0] i_req_wdata,
  // host response channel, always accepted
  output logic                          o_rsp_valid,
  output logic [periph_pkg::DATA_W-1:0] o_rsp_rdata,
  output logic                          o_rsp_err,
  // board pins
  input  logic [periph_pkg::SW_W-1:0]   i_sw,
  output logic [periph_pkg::LED_W-1:0]  o_led,
  output logic                          o_uart_tx
);

  // router to gpio block
  reg_bus_if bus_gpio ();
  // router to uart transmitter
  reg_bus_if bus_uart ();

  // decode, error check and response merge
  bus_router i_bus_router (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req_op    (i_req_op),
    .i_req_addr  (i_req_addr),
    .i_req_wdata (i_req_wdata),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp_rdata (o_rsp_rdata),
    .o_rsp_err   (o_rsp_err),
    .gpio_bus    (bus_gpio),
    .uart_bus    (bus_uart)
  );

  // leds and switches
  gpio_regs i_gpio_regs (
    .clk   (clk),
    .i_rst (i_rst),
    .bus   (bus_gpio),
    .i_sw  (i_sw),
    .o_led (o_led)
  );

  // serial output, bit rate set by CLKS_PER_BIT
  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_uart_tx (
    .clk       (clk),
    .i_rst     (i_rst),
    .bus       (bus_uart),
    .o_uart_tx (o_uart_tx)
  );

endmodule

/* test/periph_top_tb.sv */
// testbench for the peripheral subsystem top level
// clock and reset, stimulus table, uart line decoder
// compare tasks and watchdog

module periph_top_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLKS_PER_BIT = 4;
  localparam int RESET_CYCLES = 5;
  localparam int DW           = periph_pkg::DATA_W;

  // one table row, request plus expected response
  typedef struct packed {
    periph_pkg::bus_op_e   op;
    periph_pkg::reg_addr_e addr;
    logic [DW-1:0]         wdata;
    logic [DW-1:0]         exp_rdata;
    logic                  exp_err;
    // transmitter busy, response held off past 2 cycles
    logic                  stall;
  } entry_t;

  logic                          clk;
  logic                          rst;
  logic                          req_valid;
  logic                          req_ready;
  periph_pkg::bus_op_e           req_op;
  periph_pkg::reg_addr_e         req_addr;
  logic [DW-1:0]                 req_wdata;
  logic                          rsp_valid;
  logic [DW-1:0]                 rsp_rdata;
  logic                          rsp_err;
  logic [periph_pkg::SW_W-1:0]   sw;
  logic [periph_pkg::LED_W-1:0]  led;
  logic                          uart_tx;

  entry_t                         stim_q[$];
  // led value expected from the or/and-not rule
  logic [periph_pkg::LED_W-1:0]   led_model;
  logic [uart_pkg::DATA_BITS-1:0] exp_bytes[$];
  logic [uart_pkg::DATA_BITS-1:0] rx_bytes[$];

  periph_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_periph_top (
    .clk         (clk),
    .i_rst       (rst),
    .i_req_valid (req_valid),
    .o_req_ready (req_ready),
    .i_req_op    (req_op),
    .i_req_addr  (req_addr),
    .i_req_wdata (req_wdata),
    .o_rsp_valid (rsp_valid),
    .o_rsp_rdata (rsp_rdata),
    .o_rsp_err   (rsp_err),
    .i_sw        (sw),
    .o_led       (led),
    .o_uart_tx   (uart_tx)
  );

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string msg);
    $display("t=%0t %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_data(input string name, input logic [DW-1:0] got,
                            input logic [DW-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got 0x%h, expected 0x%h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got %b, expected %b", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "error flag mismatch");
    end
  endtask

  task automatic check_led(input string name, input logic [periph_pkg::LED_W-1:0] got,
                           input logic [periph_pkg::LED_W-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got 0x%h, expected 0x%h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "led mismatch");
    end
  endtask

  // single status bits such as ready and the serial line
  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got %b, expected %b", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "status bit mismatch");
    end
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge clk);
    abort_run($sformatf("timeout, no end of test after %0d cycles", cycles));
  endtask

  task automatic add_entry(input periph_pkg::bus_op_e op, input periph_pkg::reg_addr_e addr,
                           input logic [DW-1:0] wdata, input logic [DW-1:0] exp_rdata,
                           input logic exp_err, input logic stall);
    entry_t e;
    e.op        = op;
    e.addr      = addr;
    e.wdata     = wdata;
    e.exp_rdata = exp_rdata;
    e.exp_err   = exp_err;
    e.stall     = stall;
    stim_q.push_back(e);
  endtask

  task automatic build_table();
    // led write, set, clear and read back, writes return the new value
    add_entry(periph_pkg::OP_WRITE, periph_pkg::REG_LED, 8'h3c, 8'h3c, 1'b0, 1'b0);
    add_entry(periph_pkg::OP_SET,   periph_pkg::REG_LED, 8'h81, 8'hbd, 1'b0, 1'b0);
    add_entry(periph_pkg::OP_CLEAR, periph_pkg::REG_LED, 8'h0f, 8'hb0, 1'b0, 1'b0);
    add_entry(periph_pkg::OP_READ,  periph_pkg::REG_LED, 8'h00, 8'hb0, 1'b0, 1'b0);
    // switches zero extended, idle status
    add_entry(periph_pkg::OP_READ, periph_pkg::REG_SW, 8'h00, DW'(sw), 1'b0, 1'b0);
    add_entry(periph_pkg::OP_READ, periph_pkg::REG_UART_STAT, 8'h00, 8'h00, 1'b0, 1'b0);
    // illegal ops answered by the router with zero data
    add_entry(periph_pkg::OP_SET,   periph_pkg::REG_SW,        8'hff, 8'h00, 1'b1, 1'b0);
    add_entry(periph_pkg::OP_CLEAR, periph_pkg::REG_UART_DATA, 8'h01, 8'h00, 1'b1, 1'b0);
    add_entry(periph_pkg::OP_WRITE, periph_pkg::REG_SW,        8'h55, 8'h00, 1'b1, 1'b0);
    add_entry(periph_pkg::OP_WRITE, periph_pkg::REG_UART_STAT, 8'h01, 8'h00, 1'b1, 1'b0);
    add_entry(periph_pkg::OP_SET,   periph_pkg::REG_UART_STAT, 8'h02, 8'h00, 1'b1, 1'b0);
    add_entry(periph_pkg::OP_READ,  periph_pkg::REG_LED,       8'h00, 8'hb0, 1'b0, 1'b0);
    // uart bytes, later writes wait for the frame in progress
    add_entry(periph_pkg::OP_WRITE, periph_pkg::REG_UART_DATA, 8'h5a, 8'h00, 1'b0, 1'b0);
    add_entry(periph_pkg::OP_READ,  periph_pkg::REG_UART_STAT, 8'h00, 8'h01, 1'b0, 1'b0);
    add_entry(periph_pkg::OP_WRITE, periph_pkg::REG_UART_DATA, 8'hc3, 8'h00, 1'b0, 1'b1);
    add_entry(periph_pkg::OP_WRITE, periph_pkg::REG_UART_DATA, 8'h81, 8'h00, 1'b0, 1'b1);
    add_entry(periph_pkg::OP_READ,  periph_pkg::REG_UART_STAT, 8'h00, 8'h01, 1'b0, 1'b0);
    add_entry(periph_pkg::OP_SET,   periph_pkg::REG_LED,       8'h0a, 8'hba, 1'b0, 1'b0);
  endtask

  task automatic apply_entry(input int idx, input entry_t e);
    int lat;
    @(posedge clk);
    #2;
    req_valid = 1'b1;
    req_op    = e.op;
    req_addr  = e.addr;
    req_wdata = e.wdata;
    // ready moves only on edges, so the negedge value holds at the next edge
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    lat = 0;
    @(negedge clk);
    while (!rsp_valid) begin
      check_flag($sformatf("o_req_ready, entry %0d", idx), req_ready, 1'b0);
      lat++;
      @(negedge clk);
    end
    if (e.stall) begin
      if (lat <= 2) begin
        abort_run($sformatf("entry %0d was not held off by the busy transmitter", idx));
      end
    end else if (lat != 2) begin
      abort_run($sformatf("entry %0d answered %0d cycles after acceptance, not 2", idx, lat));
    end
    check_err($sformatf("o_rsp_err, entry %0d", idx), rsp_err, e.exp_err);
    check_data($sformatf("o_rsp_rdata, entry %0d", idx), rsp_rdata, e.exp_rdata);
    if (!e.exp_err && (e.addr == periph_pkg::REG_LED)) begin
      case (e.op)
        periph_pkg::OP_WRITE: led_model = e.wdata[periph_pkg::LED_W-1:0];
        periph_pkg::OP_SET:   led_model = led_model | e.wdata[periph_pkg::LED_W-1:0];
        periph_pkg::OP_CLEAR: led_model = led_model & ~e.wdata[periph_pkg::LED_W-1:0];
        default:              led_model = led_model;
      endcase
    end
    if (!e.exp_err && (e.op == periph_pkg::OP_WRITE) && (e.addr == periph_pkg::REG_UART_DATA)) begin
      exp_bytes.push_back(e.wdata[uart_pkg::DATA_BITS-1:0]);
    end
    check_led($sformatf("o_led, entry %0d", idx), led, led_model);
  endtask

  // serial decoder, samples on negedges so the line is stable
  initial begin : uart_monitor
    logic [uart_pkg::DATA_BITS-1:0] rx_byte;
    @(negedge rst);
    forever begin
      @(negedge uart_tx);
      // half a bit into the start bit
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      if (uart_tx !== 1'b0) begin
        abort_run("start bit on o_uart_tx went high before mid-bit");
      end
      // lsb first
      for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        rx_byte[i] = uart_tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      check_flag("o_uart_tx stop bit", uart_tx, 1'b1);
      rx_bytes.push_back(rx_byte);
    end
  end

  initial begin : main
    logic [31:0] rnd;
    rnd       = xorshift(32'd75);
    rst       = 1'b1;
    req_valid = 1'b0;
    req_op    = periph_pkg::OP_READ;
    req_addr  = periph_pkg::REG_LED;
    req_wdata = '0;
    // switches stay fixed for the whole run
    sw        = rnd[periph_pkg::SW_W-1:0];
    led_model = '0;
    build_table();
    fork
      watchdog(stim_q.size() * (2 + 10 * CLKS_PER_BIT) + RESET_CYCLES);
    join_none
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    check_flag("o_uart_tx after reset", uart_tx, 1'b1);
    check_led("o_led after reset", led, '0);
    check_flag("o_req_ready after reset", req_ready, 1'b1);
    check_flag("o_rsp_valid after reset", rsp_valid, 1'b0);
    check_err("o_rsp_err after reset", rsp_err, 1'b0);
    foreach (stim_q[i]) begin
      apply_entry(i, stim_q[i]);
    end
    // the last frames are still on the line
    while (rx_bytes.size() < exp_bytes.size()) @(posedge clk);
    foreach (exp_bytes[i]) begin
      check_data($sformatf("o_uart_tx byte %0d", i), rx_bytes[i], exp_bytes[i]);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* compile.f */
design/periph_pkg.sv
design/uart_pkg.sv
design/reg_bus_if.sv
design/gpio_regs.sv
design/uart_tx.sv
design/bus_router.sv
design/periph_top.sv
test/periph_top_tb.sv

/* Makefile */
# Verilator build and run of the peripheral subsystem testbench

TOP = periph_top_tb

.PHONY: sim clean

sim:
	verilator --binary --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
